//--- adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

    parameter int SAMPLE_W         = 12;
    parameter int SAMPLES_PER_WORD = 3;
    parameter int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // smp[2] holds the oldest sample, nib[8] the top nibble
    typedef union packed {
        sample_t [SAMPLES_PER_WORD-1:0] smp;    // low-res view
        logic [8:0][3:0]                nib;    // high-res view
    } packed_word_u;

    // bit positions in error_stat
    parameter int ERR_CLIP      = 2;
    parameter int ERR_OVERFLOW  = 1;
    parameter int ERR_UNDERFLOW = 0;

    parameter int UNDERFLOW_MAX = 255;    // 8-bit count saturates here

endpackage

`default_nettype wire

//--- adc_capture_props.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_props #(
    parameter int AW = 4
) (
    input wire          clk_i,
    input wire          rst_i,
    input wire          empty_i,
    input wire [AW-1:0] wr_ptr_i,
    input wire [AW-1:0] rd_ptr_i,
    input wire          wr_i,
    input wire          ovf_i,
    input wire          cap_wr_i,
    input wire [1:0]    state_i
);

    localparam logic [1:0] ST_TRIG = 2'd1;

    // read pointer must stay put while the FIFO is empty
    pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(empty_i) |-> (rd_ptr_i == $past(rd_ptr_i)))
        else $error("pop accepted while FIFO empty");

    // full seen through the pointers rather than the count
    ovf_needs_full_wr: assert property (@(posedge clk_i) disable iff (rst_i)
        ovf_i |-> $past(wr_i && !empty_i && (wr_ptr_i == rd_ptr_i)))
        else $error("overflow without full write");

    cap_wr_in_trig: assert property (@(posedge clk_i) disable iff (rst_i)
        cap_wr_i |-> (state_i == ST_TRIG)) else $error("sample written outside capture");

endmodule

bind adc_capture_top adc_capture_props #(
    .AW ($clog2(FIFO_DEPTH))
) u_props (
    .clk_i    (adc_sampleclk),
    .rst_i    (fifo_rst),
    .empty_i  (u_fifo.empty_o),
    .wr_ptr_i (u_fifo.wr_ptr),
    .rd_ptr_i (u_fifo.rd_ptr),
    .wr_i     (u_fifo.wr_i),
    .ovf_i    (u_fifo.ovf_o),
    .cap_wr_i (u_ctrl.cap_wr_o),
    .state_i  (u_ctrl.state)
);

`default_nettype wire

//--- adc_capture_tb.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_tb;

    localparam int PERIOD  = 8;
    localparam int N_CAPT  = 13;    // 6 random + 4 high-res + 1 overflow + 2 clip
    localparam int MAX_SMP = 64;
    localparam int MAX_DS  = 4;     // downsample + 1
    localparam int READ_LN = 60;
    localparam int LIMIT   = N_CAPT * (MAX_SMP * MAX_DS + READ_LN + 40) * PERIOD;

    logic        adc_sampleclk = 1'b0;
    logic        fifo_rst = 1'b1;
    logic [11:0] adc_datain = 12'h000;
    logic [12:0] downsample = 13'd0;
    logic        capture_go = 1'b0;
    logic [31:0] max_samples = 32'd3;
    logic        no_clip_errors = 1'b0;
    logic        fifo_read_en = 1'b0;
    logic        low_res = 1'b1;
    logic        low_res_lsb = 1'b0;
    logic        clear_errors = 1'b0;
    logic        no_underflow_errors = 1'b0;
    logic        capture_stop;
    logic [7:0]  fifo_read_data;
    logic [2:0]  error_stat;
    logic        error_flag;
    logic [7:0]  underflow_count;
    logic        fifo_overflow;

    logic [11:0] step = 12'd1;
    logic        hold_max = 1'b0;
    logic [11:0] exp_q[$];    // decimated samples seen while capture_go is high
    logic [7:0]  rd_q[$];
    int          dcnt;

    adc_capture_top #(.FIFO_DEPTH(16)) dut0 (
        .adc_sampleclk (adc_sampleclk), .fifo_rst (fifo_rst),
        .adc_datain_i (adc_datain), .downsample_i (downsample),
        .capture_go_i (capture_go), .max_samples_i (max_samples),
        .no_clip_errors_i (no_clip_errors), .capture_stop_o (capture_stop),
        .fifo_read_en_i (fifo_read_en), .low_res_i (low_res),
        .low_res_lsb_i (low_res_lsb), .fifo_read_data_o (fifo_read_data),
        .clear_errors_i (clear_errors), .no_underflow_errors_i (no_underflow_errors),
        .error_stat_o (error_stat), .error_flag_o (error_flag),
        .underflow_count_o (underflow_count), .fifo_overflow_o (fifo_overflow)
    );

    always #(PERIOD/2) adc_sampleclk = ~adc_sampleclk;

    always @(posedge adc_sampleclk)
        adc_datain <= hold_max ? 12'hFFF : adc_datain + step;    // ramp

    // reference decimator, free-running from reset
    always @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            dcnt = 0;
        end else if (dcnt == int'(downsample)) begin
            dcnt = 0;
            if (capture_go)
                exp_q.push_back(adc_datain);
        end else begin
            dcnt = dcnt + 1;
        end
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired before the tests completed");
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "compare error");
        end
    endtask

    task automatic run_capture(input int ms, input int ds);
        @(posedge adc_sampleclk);
        downsample  <= 13'(ds);
        max_samples <= 32'(ms);
        fifo_rst    <= 1'b1;
        repeat (2) @(posedge adc_sampleclk);
        fifo_rst <= 1'b0;
        exp_q.delete();
        @(posedge adc_sampleclk);
        capture_go <= 1'b1;
        while (!capture_stop)
            @(posedge adc_sampleclk);
        @(posedge adc_sampleclk);
        check("capture_stop_o", capture_stop, 1);    // held while capture_go is high
        capture_go <= 1'b0;
        repeat (4) @(posedge adc_sampleclk);    // last word reaches the FIFO
        check("capture_stop_o", capture_stop, 0);
    endtask

    task automatic read_bytes(input int n);
        rd_q.delete();
        @(posedge adc_sampleclk);
        fifo_read_en <= 1'b1;
        for (int i = 0; i < n; i++) begin
            @(negedge adc_sampleclk);
            rd_q.push_back(fifo_read_data);
            @(posedge adc_sampleclk);
            if (i == n - 1)
                fifo_read_en <= 1'b0;
        end
    endtask

    task automatic check_low_res(input int n);
        logic [11:0] s;
        for (int i = 0; i < n; i++) begin
            s = exp_q[i];
            check("fifo_read_data_o", rd_q[i], low_res_lsb ? s[7:0] : s[11:4]);
        end
    endtask

    initial begin
        int ms;
        int words;
        logic [71:0] grp;
        void'($urandom(32'haa9f9dbc));
        step = 12'($urandom) | 12'd1;    // odd step
        repeat (2) @(posedge adc_sampleclk);
        fifo_rst <= 1'b0;

        // capture length, low-res readout and underflow
        for (int t = 0; t < 6; t++) begin
            ms    = 1 + ($urandom % 40);
            words = (ms + 2) / 3;
            low_res             <= 1'b1;
            low_res_lsb         <= 1'(t >> 1);
            no_underflow_errors <= 1'(t);
            run_capture(ms, $urandom % 4);
            read_bytes(3 * words);
            check_low_res(3 * words);
            check("underflow_count_o", underflow_count, 0);
            read_bytes(6);    // two pops past empty
            for (int i = 0; i < 6; i++)
                check("fifo_read_data_o", rd_q[i], 0);
            repeat (3) @(posedge adc_sampleclk);
            check("underflow_count_o", underflow_count, 2);
            check("error_stat_o[0]", error_stat[0], !no_underflow_errors);
        end

        // high-res readout, even word count
        for (int t = 0; t < 4; t++) begin
            words = 2 * (1 + ($urandom % 7));
            low_res <= 1'b0;
            run_capture(3 * words, $urandom % 4);
            read_bytes(9 * words / 2);
            for (int g = 0; g < words / 2; g++) begin
                for (int b = 0; b < 9; b++)
                    grp[71 - 8*b -: 8] = rd_q[9*g + b];
                for (int k = 0; k < 6; k++)
                    check("hi_res_sample", grp[71 - 12*k -: 12], exp_q[6*g + k]);
            end
        end

        // overflow with 20 words into 16 slots
        low_res     <= 1'b1;
        low_res_lsb <= 1'b0;
        run_capture(60, $urandom % 4);
        check("error_stat_o[1]", error_stat[1], 1);
        check("error_flag_o", error_flag, 1);
        check("fifo_overflow_o", fifo_overflow, 1);
        read_bytes(48);
        check_low_res(48);
        clear_errors <= 1'b1;
        @(posedge adc_sampleclk);
        clear_errors <= 1'b0;
        @(negedge adc_sampleclk);
        check("error_stat_o", error_stat, 0);
        check("error_flag_o", error_flag, 0);
        check("fifo_overflow_o", fifo_overflow, 1);

        // clipping at full scale, enabled then masked
        for (int nc = 0; nc < 2; nc++) begin
            hold_max       <= 1'b1;
            no_clip_errors <= 1'(nc);
            run_capture(3, 0);
            check("error_stat_o[2]", error_stat[2], (nc == 0));
        end
        hold_max <= 1'b0;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- adc_capture_top.f
adc_capture_pkg.sv
sample_decimator.sv
capture_ctrl.sv
sample_packer.sv
word_fifo.sv
byte_reader.sv
error_status.sv
adc_capture_top.sv
adc_capture_props.sv
adc_capture_tb.sv

//--- adc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                      adc_sampleclk,
    input  wire                      fifo_rst,
    input  wire adc_capture_pkg::sample_t adc_datain_i,
    input  wire [12:0]               downsample_i,
    input  wire                      capture_go_i,
    input  wire [31:0]               max_samples_i,
    input  wire                      no_clip_errors_i,
    output logic                     capture_stop_o,
    input  wire                      fifo_read_en_i,
    input  wire                      low_res_i,
    input  wire                      low_res_lsb_i,
    output logic [7:0]               fifo_read_data_o,
    input  wire                      clear_errors_i,
    input  wire                      no_underflow_errors_i,
    output logic [2:0]               error_stat_o,
    output logic                     error_flag_o,
    output logic [7:0]               underflow_count_o,
    output logic                     fifo_overflow_o
);
    import adc_capture_pkg::*;

    logic         smp_valid;
    sample_t      smp_data;
    logic         cap_wr;
    sample_t      cap_data;
    logic         cap_last;
    logic         clip_err;
    logic         word_wr;
    packed_word_u word_data;
    packed_word_u head_word;
    logic         fifo_empty;
    logic         pop;
    logic         ovf;
    logic         udf;

    sample_decimator u_decimator (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .adc_datain_i  (adc_datain_i),
        .downsample_i  (downsample_i),
        .smp_valid_o   (smp_valid),
        .smp_data_o    (smp_data)
    );

    capture_ctrl u_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .smp_valid_i      (smp_valid),
        .smp_data_i       (smp_data),
        .capture_go_i     (capture_go_i),
        .max_samples_i    (max_samples_i),
        .no_clip_errors_i (no_clip_errors_i),
        .cap_wr_o         (cap_wr),
        .cap_data_o       (cap_data),
        .cap_last_o       (cap_last),
        .capture_stop_o   (capture_stop_o),
        .clip_err_o       (clip_err)
    );

    sample_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .cap_wr_i      (cap_wr),
        .cap_data_i    (cap_data),
        .cap_last_i    (cap_last),
        .word_wr_o     (word_wr),
        .word_data_o   (word_data)
    );

    word_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .wr_i          (word_wr),
        .data_i        (word_data),
        .pop_i         (pop),
        .head_o        (head_word),
        .empty_o       (fifo_empty),
        .ovf_o         (ovf),
        .udf_o         (udf)
    );

    byte_reader u_reader (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .fifo_read_en_i   (fifo_read_en_i),
        .low_res_i        (low_res_i),
        .low_res_lsb_i    (low_res_lsb_i),
        .head_i           (head_word),
        .empty_i          (fifo_empty),
        .udf_i            (udf),
        .pop_o            (pop),
        .fifo_read_data_o (fifo_read_data_o)
    );

    error_status u_errors (
        .adc_sampleclk         (adc_sampleclk),
        .fifo_rst              (fifo_rst),
        .clip_err_i            (clip_err),
        .ovf_i                 (ovf),
        .udf_i                 (udf),
        .clear_errors_i        (clear_errors_i),
        .no_underflow_errors_i (no_underflow_errors_i),
        .error_stat_o          (error_stat_o),
        .error_flag_o          (error_flag_o),
        .underflow_count_o     (underflow_count_o),
        .fifo_overflow_o       (fifo_overflow_o)
    );

endmodule

`default_nettype wire

//--- byte_reader.sv
`timescale 1ns/1ns
`default_nettype none

module byte_reader (
    input  wire                           adc_sampleclk,
    input  wire                           fifo_rst,
    input  wire                           fifo_read_en_i,
    input  wire                           low_res_i,
    input  wire                           low_res_lsb_i,
    input  wire adc_capture_pkg::packed_word_u head_i,
    input  wire                           empty_i,
    input  wire                           udf_i,
    output logic                          pop_o,
    output logic [7:0]                    fifo_read_data_o
);
    import adc_capture_pkg::*;

    logic [3:0] rd_cnt;       // byte position within the group
    logic [3:0] saved_nib;    // nibble 0 of the first word of a pair
    logic       udf_seen;
    logic       last_byte;
    logic [1:0] smp_sel;

    assign last_byte = low_res_i ? (rd_cnt >= 4'd2) : (rd_cnt >= 4'd8);
    assign pop_o     = fifo_read_en_i &&
                       (low_res_i ? (rd_cnt == 4'd2) : ((rd_cnt == 4'd3) || (rd_cnt == 4'd8)));
    assign smp_sel   = 2'(SAMPLES_PER_WORD - 1) - rd_cnt[1:0];    // oldest first

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            rd_cnt   <= '0;
            udf_seen <= 1'b0;
        end else begin
            if (udf_i)
                udf_seen <= 1'b1;    // sticky until reset
            if (fifo_read_en_i)
                rd_cnt <= last_byte ? 4'd0 : rd_cnt + 4'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_read_en_i && !low_res_i && (rd_cnt == 4'd3))
            saved_nib <= head_i.nib[0];
    end

    always_comb begin
        fifo_read_data_o = 8'h00;
        if (!udf_seen && !empty_i) begin
            if (low_res_i) begin
                if (low_res_lsb_i)
                    fifo_read_data_o = head_i.smp[smp_sel][7:0];
                else
                    fifo_read_data_o = head_i.smp[smp_sel][SAMPLE_W-1 -: 8];
            end else begin
                // two words give nine bytes
                case (rd_cnt)
                    4'd0:    fifo_read_data_o = {head_i.nib[8], head_i.nib[7]};
                    4'd1:    fifo_read_data_o = {head_i.nib[6], head_i.nib[5]};
                    4'd2:    fifo_read_data_o = {head_i.nib[4], head_i.nib[3]};
                    4'd3:    fifo_read_data_o = {head_i.nib[2], head_i.nib[1]};
                    4'd4:    fifo_read_data_o = {saved_nib, head_i.nib[8]};    // straddles words
                    4'd5:    fifo_read_data_o = {head_i.nib[7], head_i.nib[6]};
                    4'd6:    fifo_read_data_o = {head_i.nib[5], head_i.nib[4]};
                    4'd7:    fifo_read_data_o = {head_i.nib[3], head_i.nib[2]};
                    4'd8:    fifo_read_data_o = {head_i.nib[1], head_i.nib[0]};
                    default: fifo_read_data_o = 8'h00;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl (
    input  wire                      adc_sampleclk,
    input  wire                      fifo_rst,
    input  wire                      smp_valid_i,
    input  wire adc_capture_pkg::sample_t smp_data_i,
    input  wire                      capture_go_i,
    input  wire [31:0]               max_samples_i,
    input  wire                      no_clip_errors_i,
    output logic                     cap_wr_o,
    output adc_capture_pkg::sample_t cap_data_o,
    output logic                     cap_last_o,
    output logic                     capture_stop_o,
    output logic                     clip_err_o
);
    import adc_capture_pkg::*;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_TRIG    = 2'd1;
    localparam logic [1:0] ST_DONE    = 2'd2;
    localparam logic [1:0] LAST_PHASE = 2'(SAMPLES_PER_WORD - 1);

    logic [1:0]  state;
    logic [31:0] smp_cnt;    // samples written this capture
    logic [1:0]  phase;      // slot inside the current word
    logic        stop_now;
    logic        take;

    // stop only on a word boundary once enough samples went out
    assign stop_now = cap_wr_o && cap_last_o && (smp_cnt >= max_samples_i);
    assign take     = smp_valid_i && (state == ST_TRIG) && !stop_now;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            state          <= ST_IDLE;
            smp_cnt        <= '0;
            phase          <= '0;
            cap_wr_o       <= 1'b0;
            cap_last_o     <= 1'b0;
            capture_stop_o <= 1'b0;
            clip_err_o     <= 1'b0;
        end else begin
            cap_wr_o   <= take;
            cap_last_o <= take && (phase == LAST_PHASE);
            clip_err_o <= take && !no_clip_errors_i &&
                          ((smp_data_i == '1) || (smp_data_i == '0));    // rail hit
            if (take) begin
                phase   <= (phase == LAST_PHASE) ? 2'd0 : phase + 2'd1;
                smp_cnt <= smp_cnt + 32'd1;
            end
            case (state)
                ST_IDLE: begin
                    smp_cnt <= '0;
                    phase   <= '0;
                    if (capture_go_i)
                        state <= ST_TRIG;
                end
                ST_TRIG: begin
                    if (stop_now) begin
                        state          <= ST_DONE;
                        capture_stop_o <= 1'b1;
                    end
                end
                ST_DONE: begin
                    if (!capture_go_i) begin    // host acknowledged
                        state          <= ST_IDLE;
                        capture_stop_o <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (take)
            cap_data_o <= smp_data_i;
    end

endmodule

`default_nettype wire

//--- error_status.sv
`timescale 1ns/1ns
`default_nettype none

module error_status (
    input  wire        adc_sampleclk,
    input  wire        fifo_rst,
    input  wire        clip_err_i,
    input  wire        ovf_i,
    input  wire        udf_i,
    input  wire        clear_errors_i,
    input  wire        no_underflow_errors_i,
    output logic [2:0] error_stat_o,
    output logic       error_flag_o,
    output logic [7:0] underflow_count_o,
    output logic       fifo_overflow_o
);
    import adc_capture_pkg::*;

    logic udf_err;

    assign udf_err = udf_i && !no_underflow_errors_i;    // masked underflow

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            error_stat_o      <= '0;
            error_flag_o      <= 1'b0;
            underflow_count_o <= '0;
            fifo_overflow_o   <= 1'b0;
        end else begin
            if (ovf_i)
                fifo_overflow_o <= 1'b1;    // survives clear_errors_i
            if (clear_errors_i) begin
                error_stat_o      <= '0;
                error_flag_o      <= 1'b0;
                underflow_count_o <= '0;
            end else begin
                if (clip_err_i || ovf_i || udf_err)
                    error_flag_o <= 1'b1;
                if (clip_err_i)
                    error_stat_o[ERR_CLIP] <= 1'b1;
                if (ovf_i)
                    error_stat_o[ERR_OVERFLOW] <= 1'b1;
                if (udf_err)
                    error_stat_o[ERR_UNDERFLOW] <= 1'b1;
                if (udf_i && (underflow_count_o != 8'(UNDERFLOW_MAX)))
                    underflow_count_o <= underflow_count_o + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f adc_capture_top.f --top-module adc_capture_tb

out=$(./obj_dir/Vadc_capture_tb)
echo "$out"
grep -qx "ALL CHECKS PASSED" <<< "$out"

//--- sample_decimator.sv
`timescale 1ns/1ns
`default_nettype none

module sample_decimator (
    input  wire                      adc_sampleclk,
    input  wire                      fifo_rst,
    input  wire adc_capture_pkg::sample_t adc_datain_i,
    input  wire [12:0]               downsample_i,
    output logic                     smp_valid_o,
    output adc_capture_pkg::sample_t smp_data_o
);

    logic [12:0] ds_cnt;    // free-running decimation phase
    logic        ds_hit;

    assign ds_hit = (ds_cnt == downsample_i);

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            ds_cnt      <= '0;
            smp_valid_o <= 1'b0;
        end else if (ds_hit) begin
            ds_cnt      <= '0;
            smp_valid_o <= 1'b1;    // one strobe per period
        end else begin
            ds_cnt      <= ds_cnt + 13'd1;
            smp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (ds_hit)
            smp_data_o <= adc_datain_i;
    end

endmodule

`default_nettype wire

//--- sample_packer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_packer (
    input  wire                          adc_sampleclk,
    input  wire                          fifo_rst,
    input  wire                          cap_wr_i,
    input  wire adc_capture_pkg::sample_t cap_data_i,
    input  wire                          cap_last_i,
    output logic                         word_wr_o,
    output adc_capture_pkg::packed_word_u word_data_o
);
    import adc_capture_pkg::*;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst)
            word_wr_o <= 1'b0;
        else
            word_wr_o <= cap_wr_i && cap_last_i;    // word complete
    end

    // oldest sample ends up in the top slot
    always_ff @(posedge adc_sampleclk) begin
        if (cap_wr_i)
            word_data_o.smp <= {word_data_o.smp[SAMPLES_PER_WORD-2:0], cap_data_i};
    end

endmodule

`default_nettype wire

//--- word_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module word_fifo #(
    parameter int DEPTH = 16
) (
    input  wire                           adc_sampleclk,
    input  wire                           fifo_rst,
    input  wire                           wr_i,
    input  wire adc_capture_pkg::packed_word_u data_i,
    input  wire                           pop_i,
    output adc_capture_pkg::packed_word_u head_o,
    output logic                          empty_o,
    output logic                          ovf_o,
    output logic                          udf_o
);
    import adc_capture_pkg::*;

    localparam int AW = $clog2(DEPTH);

    packed_word_u  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          wr_ok;
    logic          pop_ok;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty_o = (count == '0);
    assign wr_ok   = wr_i && !full;    // writes into a full FIFO are lost
    assign pop_ok  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr];      // first word falls through

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf_o  <= 1'b0;
            udf_o  <= 1'b0;
        end else begin
            ovf_o <= wr_i && full;
            udf_o <= pop_i && empty_o;
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
